//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_xm23_core
FILELIST  = xm23_core.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- include/xm23_params.svh
`ifndef XM23_PARAMS_SVH
`define XM23_PARAMS_SVH

// Reset values of the two pointer registers
`define XM23_INIT_PC 16'h1000 // R7
`define XM23_INIT_SP 16'h0800 // R6

// Device space covers byte addresses 0 to XM23_DEV_SIZE-1
`define XM23_DEV_SIZE 16

// Bit positions shared by every device CSR byte
`define XM23_CSR_ENA 0 // Device enable
`define XM23_CSR_DBA 2 // Data buffer available
`define XM23_CSR_OF  3 // Overflow, event lost while DBA still set

`endif

//--- src/bus_router.sv
`timescale 1ns/1ns
`include "xm23_params.svh"

module bus_router (
	input  logic                    clock_i,
	input  logic                    arst_n_i,
	reg_port_if.router              regs,
	dev_port_if.router              dev,
	input  xm23_bus_pkg::xfer_src_e src_sel_i,
	input  xm23_bus_pkg::xfer_dst_e dst_sel_i,
	input  xm23_bus_pkg::mem_op_e   mem_op_i,
	input  logic                    byte_i,
	input  logic [3:0]              src_rnum_i,
	input  logic [3:0]              dst_rnum_i,
	input  logic [15:0]             ext_data_i
);

	import xm23_bus_pkg::*;

	logic [15:0] mar;
	logic [15:0] mdr;
	logic [15:0] src_word; // Data bus
	logic        in_dev;   // MAR points into device space

	always_comb begin
		case (src_sel_i)
			SRC_MDR: src_word = mdr;
			SRC_REG: src_word = regs.src_data;
			SRC_EXT: src_word = ext_data_i;
			default: src_word = '0;
		endcase
	end

	// Register file write port
	assign regs.src_num = src_rnum_i;
	assign regs.wr_en   = (dst_sel_i == DST_REG);
	assign regs.wr_byte = (dst_sel_i == DST_REG) && byte_i;
	assign regs.wr_num  = dst_rnum_i;
	assign regs.wr_data = src_word;

	assign in_dev = (mar < 16'(`XM23_DEV_SIZE));

	// Device strobes only inside device space
	assign dev.addr    = mar[3:0];
	assign dev.rd_en   = (mem_op_i == MEM_READ) && in_dev;
	assign dev.wr_en   = (mem_op_i == MEM_WRITE) && in_dev;
	assign dev.wr_byte = byte_i;
	assign dev.wr_data = mdr;

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mar <= '0;
		end else if (dst_sel_i == DST_MAR) begin
			mar <= src_word;
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mdr <= '0;
		end else if (dst_sel_i == DST_MDR) begin
			mdr <= src_word;
		end else if (mem_op_i == MEM_READ) begin
			mdr <= in_dev ? dev.rd_data : 16'h0000; // Unmapped reads as zero
		end
	end

	// Controller keeps memory cycles and bus transfers apart
	a_mem_alone: assert property (
		@(posedge clock_i) disable iff (!arst_n_i)
		(mem_op_i != MEM_IDLE) |-> (dst_sel_i == DST_NONE)
	);

endmodule

//--- src/dev_regs.sv
`timescale 1ns/1ns
`include "xm23_params.svh"

module dev_regs (
	input  logic        clock_i,
	input  logic        arst_n_i,
	dev_port_if.dev     dev,
	input  logic        push_button_i,
	output logic [3:0]  traffic_lights_o
);

	import xm23_dev_pkg::*;

	logic [7:0] dev_mem [`XM23_DEV_SIZE];
	logic [7:0] mem_d   [`XM23_DEV_SIZE]; // Next contents
	logic [3:0] addr_nx;                  // Second byte of a word access
	logic [7:0] tmr_cnt;
	logic [7:0] tmr_inc;
	logic       tmr_run;
	logic       tmr_fire;
	logic [1:0] pb_sync;
	logic       pb_rise;

	assign addr_nx = dev.addr + 4'd1;

	// Big-endian word view, byte reads are zero extended
	assign dev.rd_data = dev.wr_byte ? {8'h00, dev_mem[dev.addr]}
	                                 : {dev_mem[dev.addr], dev_mem[addr_nx]};

	// Timer
	assign tmr_inc  = tmr_cnt + 8'd1;
	assign tmr_run  = dev_mem[TMR_CSR][`XM23_CSR_ENA] && (dev_mem[TMR_DATA] != 8'h00);
	assign tmr_fire = tmr_run && (tmr_inc >= dev_mem[TMR_DATA]);

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tmr_cnt <= '0;
		end else if (!tmr_run || tmr_fire) begin
			tmr_cnt <= '0; // Restart the period
		end else begin
			tmr_cnt <= tmr_inc;
		end
	end

	// Pedestrian button, two stage synchroniser
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pb_sync <= '0;
		end else begin
			pb_sync <= {pb_sync[0], push_button_i};
		end
	end

	// PB_DATA bit 0 holds the previous synchronised value
	assign pb_rise = pb_sync[1] && !dev_mem[PB_DATA][0];

	always_comb begin
		mem_d = dev_mem;

		if (dev.wr_en) begin
			if (dev.wr_byte) begin
				mem_d[dev.addr] = dev.wr_data[7:0];
			end else begin
				mem_d[dev.addr] = dev.wr_data[15:8];
				mem_d[addr_nx]  = dev.wr_data[7:0];
			end
		end

		// Status bits clear once the old value has been read out
		if (dev.rd_en && (dev.addr == TMR_CSR || dev.addr == PB_CSR)) begin
			mem_d[dev.addr][`XM23_CSR_DBA] = 1'b0;
			mem_d[dev.addr][`XM23_CSR_OF]  = 1'b0;
		end

		// Device events win over a same cycle clear
		if (tmr_fire) begin
			mem_d[TMR_CSR][`XM23_CSR_OF] = mem_d[TMR_CSR][`XM23_CSR_OF]
			                               | mem_d[TMR_CSR][`XM23_CSR_DBA];
			mem_d[TMR_CSR][`XM23_CSR_DBA] = 1'b1;
		end

		mem_d[PB_DATA][0] = pb_sync[1];
		if (pb_rise) begin
			mem_d[PB_CSR][`XM23_CSR_OF] = mem_d[PB_CSR][`XM23_CSR_OF]
			                              | mem_d[PB_CSR][`XM23_CSR_DBA];
			mem_d[PB_CSR][`XM23_CSR_DBA] = 1'b1;
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `XM23_DEV_SIZE; i++) begin
				dev_mem[i] <= '0;
			end
		end else begin
			dev_mem <= mem_d;
		end
	end

	// Lamps dark unless the controller is enabled
	assign traffic_lights_o = dev_mem[TL_CSR][`XM23_CSR_ENA] ? dev_mem[TL_DATA][3:0] : 4'h0;

	// A read and a write to device space never share a cycle
	a_no_rd_wr: assert property (
		@(posedge clock_i) disable iff (!arst_n_i)
		!(dev.rd_en && dev.wr_en)
	);

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ns
`include "xm23_params.svh"

module reg_file (
	input  logic          clock_i,
	input  logic          arst_n_i,
	reg_port_if.regs      regs,
	input  logic [3:0]    view_rnum_i,
	output logic [15:0]   view_data_o
);

	logic [15:0] gpr [8]; // R0 to R7

	// Constant generator behind R8 to R15
	function automatic logic [15:0] const_word(input logic [2:0] idx);
		logic [15:0] val;
		case (idx)
			3'd0:    val = 16'h0000;
			3'd1:    val = 16'h0001;
			3'd2:    val = 16'h0002;
			3'd3:    val = 16'h0004;
			3'd4:    val = 16'h0008;
			3'd5:    val = 16'h0010;
			3'd6:    val = 16'h0020;
			default: val = 16'hffff;
		endcase
		return val;
	endfunction

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 6; i++) begin
				gpr[i] <= '0;
			end
			gpr[6] <= `XM23_INIT_SP;
			gpr[7] <= `XM23_INIT_PC;
		end else if (regs.wr_en && !regs.wr_num[3]) begin // Constants are read only
			if (regs.wr_byte) begin
				gpr[regs.wr_num[2:0]][7:0] <= regs.wr_data[7:0];
			end else begin
				gpr[regs.wr_num[2:0]] <= regs.wr_data;
			end
		end
	end

	// Source read for the router
	assign regs.src_data = regs.src_num[3] ? const_word(regs.src_num[2:0])
	                                       : gpr[regs.src_num[2:0]];

	// Debug view
	assign view_data_o = view_rnum_i[3] ? const_word(view_rnum_i[2:0])
	                                    : gpr[view_rnum_i[2:0]];

	// Router never asks for a byte write that is not also a write
	a_byte_needs_wr: assert property (
		@(posedge clock_i) disable iff (!arst_n_i)
		regs.wr_byte |-> regs.wr_en
	);

endmodule

//--- src/xm23_bus_pkg.sv
package xm23_bus_pkg;

	// Where the word on the data bus comes from
	typedef enum logic [1:0] {
		SRC_MDR,
		SRC_REG,
		SRC_EXT // Result from the external ALU
	} xfer_src_e;

	// Where the selected word is written
	typedef enum logic [1:0] {
		DST_NONE,
		DST_MAR,
		DST_MDR,
		DST_REG
	} xfer_dst_e;

	// Memory access issued through MAR and MDR
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

endpackage

//--- src/xm23_core.sv
`timescale 1ns/1ns

module xm23_core (
	input  logic                    clock_i,
	input  logic                    arst_n_i,
	input  xm23_bus_pkg::xfer_src_e src_sel_i,
	input  xm23_bus_pkg::xfer_dst_e dst_sel_i,
	input  xm23_bus_pkg::mem_op_e   mem_op_i,
	input  logic                    byte_i,
	input  logic [3:0]              src_rnum_i,
	input  logic [3:0]              dst_rnum_i,
	input  logic [15:0]             ext_data_i,
	input  logic                    push_button_i,
	input  logic [3:0]              view_rnum_i,
	output logic [15:0]             view_data_o,
	output logic [3:0]              traffic_lights_o
);

	reg_port_if regs_bus ();
	dev_port_if dev_bus ();

	reg_file u_reg_file (
		.clock_i     (clock_i),
		.arst_n_i    (arst_n_i),
		.regs        (regs_bus.regs),
		.view_rnum_i (view_rnum_i),
		.view_data_o (view_data_o)
	);

	dev_regs u_dev_regs (
		.clock_i          (clock_i),
		.arst_n_i         (arst_n_i),
		.dev              (dev_bus.dev),
		.push_button_i    (push_button_i),
		.traffic_lights_o (traffic_lights_o)
	);

	// Stands in for the CPU data path between the two storage blocks
	bus_router u_bus_router (
		.clock_i    (clock_i),
		.arst_n_i   (arst_n_i),
		.regs       (regs_bus.router),
		.dev        (dev_bus.router),
		.src_sel_i  (src_sel_i),
		.dst_sel_i  (dst_sel_i),
		.mem_op_i   (mem_op_i),
		.byte_i     (byte_i),
		.src_rnum_i (src_rnum_i),
		.dst_rnum_i (dst_rnum_i),
		.ext_data_i (ext_data_i)
	);

endmodule

//--- src/xm23_dev_pkg.sv
package xm23_dev_pkg;

	// Byte offsets of the devices in device space
	typedef enum logic [3:0] {
		TMR_CSR  = 4'd0,
		TMR_DATA = 4'd1, // Timer period in cycles
		TL_CSR   = 4'd6,
		TL_DATA  = 4'd7, // Low nibble drives the lamps
		PB_CSR   = 4'd8,
		PB_DATA  = 4'd9  // Bit 0 holds the synchronised button
	} dev_reg_e;

endpackage

//--- src/xm23_ifs.sv
`timescale 1ns/1ns

// Register file access from the bus router
interface reg_port_if;
	logic [3:0]  src_num;
	logic [15:0] src_data; // Combinational read of src_num
	logic        wr_en;
	logic        wr_byte;  // Only the low byte is written
	logic [3:0]  wr_num;
	logic [15:0] wr_data;

	modport router (
		output src_num,
		output wr_en,
		output wr_byte,
		output wr_num,
		output wr_data,
		input  src_data
	);

	modport regs (
		input  src_num,
		input  wr_en,
		input  wr_byte,
		input  wr_num,
		input  wr_data,
		output src_data
	);
endinterface

// Device memory access from the bus router
interface dev_port_if;
	logic [3:0]  addr;
	logic        rd_en;
	logic        wr_en;
	logic        wr_byte; // Byte size for reads as well as writes
	logic [15:0] wr_data;
	logic [15:0] rd_data;

	modport router (
		output addr,
		output rd_en,
		output wr_en,
		output wr_byte,
		output wr_data,
		input  rd_data
	);

	modport dev (
		input  addr,
		input  rd_en,
		input  wr_en,
		input  wr_byte,
		input  wr_data,
		output rd_data
	);
endinterface

//--- test/tb_xm23_core.sv
`timescale 1ns/1ns
`include "xm23_params.svh"

module tb_xm23_core;

	import xm23_bus_pkg::*;
	import xm23_dev_pkg::*;

	localparam int CMD_COUNT   = 110; // Bus commands, poll limit included
	localparam int IDLE_CYCLES = 50;  // Reset, view sweep and device waits
	localparam int WATCHDOG_NS = (2 * CMD_COUNT + IDLE_CYCLES) * 4 + 200;
	localparam int MAX_POLLS   = 8;

	logic        clock_i;
	logic        arst_n_i;
	xfer_src_e   src_sel_i;
	xfer_dst_e   dst_sel_i;
	mem_op_e     mem_op_i;
	logic        byte_i;
	logic [3:0]  src_rnum_i;
	logic [3:0]  dst_rnum_i;
	logic [15:0] ext_data_i;
	logic        push_button_i;
	logic [3:0]  view_rnum_i;
	logic [15:0] view_data_o;
	logic [3:0]  traffic_lights_o;

	// Reference model
	logic [15:0] m_reg   [16];
	logic [15:0] m_known [16]; // Bits of each register the model can predict
	logic [15:0] m_mar;
	logic [15:0] m_mdr;
	logic [15:0] m_mdr_known;
	logic [7:0]  m_dev   [16];
	logic [3:0]  m_lights;
	logic [31:0] lfsr;
	logic [15:0] rnd;
	logic        seen;
	int          polls;

	xm23_core dut (.*);

	assign m_lights = m_dev[TL_CSR][`XM23_CSR_ENA] ? m_dev[TL_DATA][3:0] : 4'h0;

	initial begin
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i;
	end

	task automatic report_mismatch(input string name, input logic [15:0] got,
	                               input logic [15:0] exp);
		$display("Fail %s: got %h, expected %h", name, got, exp);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	a_view: assert property (
		@(posedge clock_i) disable iff (!arst_n_i)
		((view_data_o ^ m_reg[view_rnum_i]) & m_known[view_rnum_i]) == 16'h0000
	) else report_mismatch("view_data_o", $sampled(view_data_o), $sampled(m_reg[view_rnum_i]));

	a_lights: assert property (
		@(posedge clock_i) disable iff (!arst_n_i)
		traffic_lights_o == m_lights
	) else report_mismatch("traffic_lights_o", {12'h000, $sampled(traffic_lights_o)},
	                       {12'h000, $sampled(m_lights)});

	// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			val  = {val[14:0], lfsr[0]};
		end
	endtask

	// Drives one command, then retires it in the model on the edge that executes it
	task automatic issue(input xfer_src_e src, input xfer_dst_e dst, input mem_op_e op,
	                     input logic byt, input logic [3:0] srn, input logic [3:0] drn,
	                     input logic [15:0] ext, input logic [15:0] rd_known);
		logic [15:0] word;
		logic [15:0] known;
		logic [3:0]  a;
		logic [3:0]  a1;
		@(posedge clock_i);
		src_sel_i  <= src;
		dst_sel_i  <= dst;
		mem_op_i   <= op;
		byte_i     <= byt;
		src_rnum_i <= srn;
		dst_rnum_i <= drn;
		ext_data_i <= ext;
		if (dst == DST_REG) begin
			view_rnum_i <= drn; // Watch the register being written
		end
		@(posedge clock_i);
		dst_sel_i <= DST_NONE;
		mem_op_i  <= MEM_IDLE;
		byte_i    <= 1'b0;
		case (src)
			SRC_MDR: begin
				word  = m_mdr;
				known = m_mdr_known;
			end
			SRC_REG: begin
				word  = m_reg[srn];
				known = m_known[srn];
			end
			default: begin
				word  = ext;
				known = 16'hffff;
			end
		endcase
		a  = m_mar[3:0];
		a1 = a + 4'd1;
		if (dst == DST_MAR) begin
			m_mar = word;
		end else if (dst == DST_MDR) begin
			m_mdr       = word;
			m_mdr_known = known;
		end else if (dst == DST_REG && !drn[3]) begin // R8 to R15 are constants
			m_reg[drn][7:0]   = word[7:0];
			m_known[drn][7:0] = known[7:0];
			if (!byt) begin
				m_reg[drn][15:8]   = word[15:8];
				m_known[drn][15:8] = known[15:8];
			end
		end
		if (op == MEM_WRITE && m_mar < 16'(`XM23_DEV_SIZE)) begin
			m_dev[a] = byt ? m_mdr[7:0] : m_mdr[15:8]; // Big endian word
			if (!byt) begin
				m_dev[a1] = m_mdr[7:0];
			end
		end else if (op == MEM_READ) begin
			m_mdr       = 16'h0000; // Outside device space
			m_mdr_known = 16'hffff;
			if (m_mar < 16'(`XM23_DEV_SIZE)) begin
				m_mdr       = byt ? {8'h00, m_dev[a]} : {m_dev[a], m_dev[a1]};
				m_mdr_known = rd_known;
				if (a == TMR_CSR || a == PB_CSR) begin
					m_dev[a][`XM23_CSR_DBA] = 1'b0;
					m_dev[a][`XM23_CSR_OF]  = 1'b0;
				end
			end
		end
	endtask

	task automatic ext_to(input xfer_dst_e dst, input logic [3:0] rn, input logic [15:0] val);
		issue(SRC_EXT, dst, MEM_IDLE, 1'b0, 4'd0, rn, val, 16'hffff);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [15:0] data, input logic byt);
		ext_to(DST_MAR, 4'd0, addr);
		ext_to(DST_MDR, 4'd0, data);
		issue(SRC_MDR, DST_NONE, MEM_WRITE, byt, 4'd0, 4'd0, 16'h0000, 16'hffff);
	endtask

	// Result lands in register rn where the view port can see it
	task automatic mem_read(input logic [15:0] addr, input logic byt, input logic [3:0] rn,
	                        input logic [15:0] known);
		ext_to(DST_MAR, 4'd0, addr);
		issue(SRC_MDR, DST_NONE, MEM_READ, byt, 4'd0, 4'd0, 16'h0000, known);
		issue(SRC_MDR, DST_REG, MEM_IDLE, 1'b0, 4'd0, rn, 16'h0000, 16'hffff);
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_error("Watchdog timeout, the tests did not finish in time");
	end

	initial begin
		lfsr          = 32'hf84b_14f5;
		arst_n_i      = 1'b0;
		src_sel_i     = SRC_MDR;
		dst_sel_i     = DST_NONE;
		mem_op_i      = MEM_IDLE;
		byte_i        = 1'b0;
		src_rnum_i    = 4'd0;
		dst_rnum_i    = 4'd0;
		ext_data_i    = 16'h0000;
		push_button_i = 1'b0;
		view_rnum_i   = 4'd0;
		m_mar         = 16'h0000;
		m_mdr         = 16'h0000;
		m_mdr_known   = 16'hffff;
		for (int i = 0; i < 16; i++) begin
			m_dev[i]   = 8'h00;
			m_known[i] = 16'hffff;
			m_reg[i]   = (i == 6) ? `XM23_INIT_SP : (i == 7) ? `XM23_INIT_PC : 16'h0000;
			if (i > 8) begin
				m_reg[i] = (i == 15) ? 16'hffff : 16'h0001 << (i - 9); // Powers of two
			end
		end
		repeat (2) @(posedge clock_i);
		arst_n_i <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(posedge clock_i);
			view_rnum_i <= 4'(i);
		end

		for (int r = 0; r < 16; r++) begin // Upper half must keep its constants
			take_bits(16, rnd);
			ext_to(DST_REG, 4'(r), rnd);
		end
		take_bits(16, rnd);
		issue(SRC_EXT, DST_REG, MEM_IDLE, 1'b1, 4'd0, 4'd3, rnd, 16'hffff);
		issue(SRC_REG, DST_REG, MEM_IDLE, 1'b0, 4'd3, 4'd5, 16'h0000, 16'hffff);

		// TL_CSR high byte, TL_DATA low byte
		take_bits(8, rnd);
		mem_write(16'(TL_CSR), {8'h01, rnd[7:0]}, 1'b0);
		mem_read(16'(TL_CSR), 1'b0, 4'd1, 16'hffff);
		take_bits(8, rnd);
		mem_write(16'(TL_DATA), rnd, 1'b1);
		mem_read(16'(TL_DATA), 1'b1, 4'd2, 16'hffff);
		mem_read(16'(TL_DATA), 1'b0, 4'd2, 16'hffff);
		take_bits(12, rnd);
		ext_to(DST_MDR, 4'd0, 16'ha5a5);
		// Low nibble aliases TL_CSR, so a decode of MAR[3:0] alone would return data
		mem_read({rnd[11:0] | 12'h001, 4'(TL_CSR)}, 1'b0, 4'd4, 16'hffff);

		for (int n = 0; n < 3; n++) begin
			take_bits(8, rnd);
			mem_write(16'(TL_CSR), {8'h01, rnd[7:0]}, 1'b0);
		end
		mem_write(16'(TL_CSR), 16'h000f, 1'b0); // Lamps go dark with data still set

		mem_write(16'(TMR_DATA), 16'h0003, 1'b1);
		mem_write(16'(TMR_CSR), 16'h0001, 1'b1);
		polls = 0;
		seen  = 1'b0;
		while (!seen) begin
			if (polls == MAX_POLLS) begin
				report_error("Timer DBA was not seen within the poll limit");
			end else begin
				mem_read(16'(TMR_CSR), 1'b1, 4'd0, 16'hfff3); // DBA and OF depend on phase
				@(negedge clock_i);
				seen  = view_data_o[`XM23_CSR_DBA];
				polls = polls + 1;
			end
		end
		repeat (16) @(posedge clock_i);
		mem_write(16'(TMR_DATA), 16'h0000, 1'b1); // Period zero stops the timer
		m_dev[TMR_CSR][`XM23_CSR_DBA] = 1'b1;
		m_dev[TMR_CSR][`XM23_CSR_OF]  = 1'b1;
		mem_read(16'(TMR_CSR), 1'b1, 4'd1, 16'hffff);
		mem_read(16'(TMR_CSR), 1'b1, 4'd2, 16'hffff);

		@(posedge clock_i);
		push_button_i <= 1'b1;
		repeat (3) @(posedge clock_i);
		m_dev[PB_DATA][0]            = 1'b1;
		m_dev[PB_CSR][`XM23_CSR_DBA] = 1'b1;
		mem_read(16'(PB_DATA), 1'b1, 4'd3, 16'hffff);
		mem_read(16'(PB_CSR), 1'b1, 4'd4, 16'hffff);
		mem_read(16'(PB_CSR), 1'b1, 4'd5, 16'hffff);

		repeat (2) @(posedge clock_i);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- xm23_core.f
+incdir+include
src/xm23_bus_pkg.sv
src/xm23_dev_pkg.sv
src/xm23_ifs.sv
src/reg_file.sv
src/dev_regs.sv
src/bus_router.sv
src/xm23_core.sv
test/tb_xm23_core.sv
